//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -f vlog.f --top-module tb_vec_sequencer -o tb_vec_sequencer
	./obj_dir/tb_vec_sequencer | tee /dev/stderr | grep "Test completed successfully" > /dev/null

clean:
	rm -rf obj_dir

//--- verif/seq_testdata.txt
// unit op src_a src_b use_imm imm dest latency result
// unit 1 is the alu, unit 2 the multiplier, first two run long to fill the table
1 3 01 02 0 00 0a 1e 1000a001
2 5 03 04 0 00 0b 1c 2000b002
2 1 0a 05 0 00 0c 03 2000c003
1 2 0b 00 1 07 0d 02 1000d004
1 4 06 07 0 00 0e 01 1000e005
2 6 0e 0d 0 00 0f 04 2000f006
1 7 08 09 1 1f 10 02 10010007
2 2 10 0c 0 00 11 05 20011008
1 1 11 0a 0 00 12 01 10012009
2 3 13 14 1 05 15 02 2001500a
1 5 15 12 0 00 16 03 1001600b
1 6 01 02 0 00 0a 01 1000a00c
2 7 0a 16 0 00 17 02 2001700d
1 8 17 00 1 03 18 01 1001800e
2 9 18 17 0 00 19 06 2001900f
1 a 04 05 1 1a 1a 01 1001a010
2 b 1a 19 0 00 1b 02 2001b011
1 c 1b 1b 0 00 1c 03 1001c012
2 d 06 07 1 11 1d 01 2001d013
1 e 1d 1c 0 00 1e 02 1001e014

//--- verif/tb_vec_sequencer.sv
// ====================
// vector sequencer testbench
// unit models, program from test data, per-behavior checks
// ====================
`timescale 1ns/1ps
`default_nettype none

module tb_vec_sequencer;
    import seq_pkg::*;

    localparam int n_instr     = 20;
    localparam int n_cols      = 9;
    localparam int n_tests     = 6;
    localparam int max_cycles  = 3000;
    // data file columns
    localparam int col_fu      = 0;
    localparam int col_op      = 1;
    localparam int col_src_a   = 2;
    localparam int col_src_b   = 3;
    localparam int col_use_imm = 4;
    localparam int col_imm     = 5;
    localparam int col_dest    = 6;
    localparam int col_lat     = 7;
    localparam int col_res     = 8;

    logic                 clk;
    logic                 nrst;
    logic                 instr_valid;
    logic                 instr_ready;
    logic [fu_w-1:0]      instr_fu;
    logic [op_w-1:0]      instr_op;
    logic [reg_idx_w-1:0] instr_src_a;
    logic [reg_idx_w-1:0] instr_src_b;
    logic                 instr_use_imm;
    logic [reg_idx_w-1:0] instr_imm;
    logic [reg_idx_w-1:0] instr_dest;
    logic                 alu_start;
    logic [op_w-1:0]      alu_op;
    logic [reg_idx_w-1:0] alu_fj;
    logic [reg_idx_w-1:0] alu_fk;
    logic [reg_idx_w-1:0] alu_imm;
    logic [reg_idx_w-1:0] alu_fi;
    logic                 alu_done;
    logic [data_w-1:0]    alu_result;
    logic                 mul_start;
    logic [op_w-1:0]      mul_op;
    logic [reg_idx_w-1:0] mul_fj;
    logic [reg_idx_w-1:0] mul_fk;
    logic [reg_idx_w-1:0] mul_imm;
    logic [reg_idx_w-1:0] mul_fi;
    logic                 mul_done;
    logic [data_w-1:0]    mul_result;
    logic                 reg_wr_valid;
    logic [reg_idx_w-1:0] reg_wr_addr;
    logic [data_w-1:0]    reg_wr_data;
    logic                 reg_wr_ready;

    logic [31:0]          tdata [n_instr*n_cols];
    logic [31:0]          lfsr;
    int                   errs [n_tests];
    int                   checks;
    int                   accepted;
    int                   writes;
    int                   cycle;
    int                   total;
    bit                   first_wr_done;
    bit                   saw_full;
    bit                   written_back [n_instr];
    // indexed by unit code, 1 for the alu and 2 for the multiplier
    int                   unit_ptr [3];
    int                   unit_cur [3];
    int                   unit_cnt [3];
    bit                   hold_chk;
    logic [reg_idx_w-1:0] hold_addr;
    logic [data_w-1:0]    hold_data;

    vec_sequencer vec_sequencer_i (.*);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [31:0] field(input int idx, input int col);
        return tdata[idx*n_cols+col];
    endfunction

    task automatic expect_eq(input int t, input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errs[t]++;
            $display("Error: %s is %h, expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input int t, input string msg);
        errs[t]++;
        $display("%s", msg);
    endtask

    task automatic print_result(input int t, input string name);
        if (errs[t] == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: FAIL, %0d errors", name, errs[t]);
        end
    endtask

    task automatic reset_values();
        expect_eq(0, "alu_start", 32'(alu_start), 32'd0);
        expect_eq(0, "mul_start", 32'(mul_start), 32'd0);
        expect_eq(0, "reg_wr_valid", 32'(reg_wr_valid), 32'd0);
        expect_eq(0, "instr_ready", 32'(instr_ready), 32'd1);
    endtask

    // next instruction of unit u in program order must be the one started
    task automatic on_start(input int u, input string unit, input logic [op_w-1:0] op,
                            input logic [reg_idx_w-1:0] fj, input logic [reg_idx_w-1:0] fk,
                            input logic [reg_idx_w-1:0] imm, input logic [reg_idx_w-1:0] fi);
        int k;
        bit use_imm;
        k = unit_ptr[u];
        while (k < n_instr && field(k, col_fu) != 32'(u)) begin
            k++;
        end
        if (k >= accepted) begin
            note_failure(2, $sformatf("%s unit started with no accepted instruction left", unit));
            return;
        end
        use_imm = field(k, col_use_imm) != 0;
        expect_eq(2, {unit, "_op"}, 32'(op), field(k, col_op));
        expect_eq(2, {unit, "_fj"}, 32'(fj), field(k, col_src_a));
        expect_eq(2, {unit, "_fk"}, 32'(fk), use_imm ? 32'd0 : field(k, col_src_b));
        expect_eq(2, {unit, "_imm"}, 32'(imm), use_imm ? field(k, col_imm) : 32'd0);
        expect_eq(2, {unit, "_fi"}, 32'(fi), field(k, col_dest));
        // older results still in flight must not feed this one
        for (int j = 0; j < k; j++) begin
            checks++;
            if (!written_back[j] && (field(j, col_dest) == field(k, col_src_a) ||
                (!use_imm && field(j, col_dest) == field(k, col_src_b)))) begin
                note_failure(3,
                    $sformatf("instruction %0d started before instruction %0d wrote back",
                              k, j));
            end
        end
        unit_ptr[u] = k + 1;
        unit_cur[u] = k;
        unit_cnt[u] = int'(field(k, col_lat));
    endtask

    // oldest outstanding instruction with this dest and result
    task automatic on_write();
        int hit;
        hit = -1;
        for (int k = n_instr - 1; k >= 0; k--) begin
            if (k < accepted && !written_back[k] && field(k, col_dest) == 32'(reg_wr_addr) &&
                field(k, col_res) == reg_wr_data) begin
                hit = k;
            end
        end
        checks++;
        if (hit < 0) begin
            note_failure(1, $sformatf("Error: reg_wr_addr %h, reg_wr_data %h match no instruction",
                                      reg_wr_addr, reg_wr_data));
        end else begin
            written_back[hit] = 1'b1;
        end
        if (!first_wr_done && accepted > num_slots) begin
            note_failure(5,
                $sformatf("%0d instructions accepted before first writeback", accepted));
        end
        first_wr_done = 1'b1;
        writes++;
    endtask

    // sampled mid-cycle where outputs and inputs have settled
    task automatic sample_outputs();
        expect_eq(5, "instr_ready", 32'(instr_ready), 32'((accepted - writes) < num_slots));
        if (accepted - writes == num_slots) begin
            saw_full = 1'b1;
        end
        if (hold_chk) begin
            expect_eq(4, "reg_wr_valid", 32'(reg_wr_valid), 32'd1);
            expect_eq(4, "reg_wr_addr", 32'(reg_wr_addr), 32'(hold_addr));
            expect_eq(4, "reg_wr_data", reg_wr_data, hold_data);
        end
        hold_chk  = reg_wr_valid && !reg_wr_ready;
        hold_addr = reg_wr_addr;
        hold_data = reg_wr_data;
        if (alu_start) begin
            on_start(1, "alu", alu_op, alu_fj, alu_fk, alu_imm, alu_fi);
        end
        if (mul_start) begin
            on_start(2, "mul", mul_op, mul_fj, mul_fk, mul_imm, mul_fi);
        end
        if (reg_wr_valid && reg_wr_ready) begin
            on_write();
        end
        if (instr_valid && instr_ready) begin
            accepted++;
        end
    endtask

    task automatic drive_inputs();
        instr_valid = accepted < n_instr;
        if (accepted < n_instr) begin
            instr_fu      = fu_w'(field(accepted, col_fu));
            instr_op      = op_w'(field(accepted, col_op));
            instr_src_a   = reg_idx_w'(field(accepted, col_src_a));
            instr_src_b   = reg_idx_w'(field(accepted, col_src_b));
            instr_use_imm = field(accepted, col_use_imm) != 0;
            instr_imm     = reg_idx_w'(field(accepted, col_imm));
            instr_dest    = reg_idx_w'(field(accepted, col_dest));
        end
        reg_wr_ready = lfsr[0];
        lfsr         = lfsr_next(lfsr);
        // unit models pulse done on the last cycle of the latency
        alu_done = 1'b0;
        mul_done = 1'b0;
        if (unit_cnt[1] > 0) begin
            unit_cnt[1]--;
            alu_done   = unit_cnt[1] == 0;
            alu_result = field(unit_cur[1], col_res);
        end
        if (unit_cnt[2] > 0) begin
            unit_cnt[2]--;
            mul_done   = unit_cnt[2] == 0;
            mul_result = field(unit_cur[2], col_res);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        nrst          = 1'b0;
        instr_valid   = 1'b0;
        instr_fu      = '0;
        instr_op      = '0;
        instr_src_a   = '0;
        instr_src_b   = '0;
        instr_use_imm = 1'b0;
        instr_imm     = '0;
        instr_dest    = '0;
        alu_done      = 1'b0;
        alu_result    = '0;
        mul_done      = 1'b0;
        mul_result    = '0;
        reg_wr_ready  = 1'b0;
        lfsr          = 32'h45ab_4d5c;
        checks        = 0;
        accepted      = 0;
        writes        = 0;
        total         = 0;
        first_wr_done = 1'b0;
        saw_full      = 1'b0;
        hold_chk      = 1'b0;
        hold_addr     = '0;
        hold_data     = '0;
        errs          = '{default: 0};
        written_back  = '{default: 1'b0};
        unit_ptr      = '{default: 0};
        unit_cur      = '{default: 0};
        unit_cnt      = '{default: 0};
        $readmemh("verif/seq_testdata.txt", tdata);
        if (field(n_instr - 1, col_fu) !== 32'd1 && field(n_instr - 1, col_fu) !== 32'd2) begin
            note_failure(1, "test data file is missing or short");
        end

        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            #1;
            reset_values();
        end
        nrst = 1'b1;
        // first active edge, inputs still idle
        @(posedge clk);
        #1;
        reset_values();
        print_result(0, "reset values");

        cycle = 0;
        while (writes < n_instr && cycle < max_cycles) begin
            drive_inputs();
            @(negedge clk);
            sample_outputs();
            @(posedge clk);
            #1;
            cycle++;
        end
        if (writes < n_instr) begin
            note_failure(1, $sformatf("timeout after %0d cycles, %0d of %0d writes seen",
                                      cycle, writes, n_instr));
        end
        for (int k = 0; k < n_instr; k++) begin
            if (!written_back[k]) begin
                note_failure(1, $sformatf("instruction %0d was never written back", k));
            end
        end
        if (!saw_full) begin
            note_failure(5, "table never held eight instructions");
        end

        print_result(1, "writeback once each");
        print_result(2, "issue order and operands");
        print_result(3, "no raw hazard at start");
        print_result(4, "write port hold under stall");
        print_result(5, "table fill limit");
        for (int t = 0; t < n_tests; t++) begin
            total += errs[t];
        end
        $display("checks: %0d, errors: %0d", checks, total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/fu_lane.sv
// ====================
// functional-unit lane
// picks, dispatches and holds one instruction until writeback
// ====================
`timescale 1ns/1ps
`default_nettype none

module fu_lane #(
    parameter logic [seq_pkg::fu_w-1:0] lane_fu = seq_pkg::fu_valu
) (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic [seq_pkg::fu_w-1:0]         slot_fu      [seq_pkg::num_slots],
    input  logic [seq_pkg::st_w-1:0]         slot_status  [seq_pkg::num_slots],
    input  logic [seq_pkg::op_w-1:0]         slot_op      [seq_pkg::num_slots],
    input  logic [seq_pkg::reg_idx_w-1:0]    slot_src_a   [seq_pkg::num_slots],
    input  logic [seq_pkg::reg_idx_w-1:0]    slot_src_b   [seq_pkg::num_slots],
    input  logic                             slot_use_imm [seq_pkg::num_slots],
    input  logic [seq_pkg::reg_idx_w-1:0]    slot_imm     [seq_pkg::num_slots],
    input  logic [seq_pkg::reg_idx_w-1:0]    slot_dest    [seq_pkg::num_slots],
    input  logic                             slot_clear   [seq_pkg::num_slots],
    output logic                             dispatch,
    output logic [seq_pkg::slot_idx_w-1:0]   dispatch_slot,
    output logic                             written,
    output logic                             start,
    output logic [seq_pkg::op_w-1:0]         op,
    output logic [seq_pkg::reg_idx_w-1:0]    fj,
    output logic [seq_pkg::reg_idx_w-1:0]    fk,
    output logic [seq_pkg::reg_idx_w-1:0]    imm,
    output logic [seq_pkg::reg_idx_w-1:0]    fi,
    input  logic                             done,
    input  logic [seq_pkg::data_w-1:0]       result,
    output logic                             wb_req,
    output logic [seq_pkg::reg_idx_w-1:0]    wb_dest,
    output logic [seq_pkg::data_w-1:0]       wb_data,
    input  logic                             retire
);
    import seq_pkg::*;

    logic                  pend;
    logic                  exec;
    logic                  busy;
    logic                  pick_hit;
    logic [slot_idx_w-1:0] pick_idx;
    logic                  take;

    // oldest waiting entry of this unit
    always_comb begin
        pick_hit = 1'b0;
        pick_idx = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (slot_fu[i] == lane_fu && slot_status[i] == st_wait) begin
                pick_hit = 1'b1;
                pick_idx = slot_idx_w'(i);
            end
        end
    end

    assign busy = pend || exec || wb_req;
    assign take = !busy && pick_hit && slot_clear[pick_idx];

    // entry stays st_wait until the start cycle, so the pick still points at it
    assign dispatch      = start;
    assign dispatch_slot = pick_idx;
    assign written       = exec && done;
    assign wb_dest       = fi;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            pend   <= 1'b0;
            exec   <= 1'b0;
            start  <= 1'b0;
            wb_req <= 1'b0;
        end else begin
            start <= 1'b0;
            if (take) begin
                pend <= 1'b1;
            end
            if (pend) begin
                pend  <= 1'b0;
                start <= 1'b1;
                exec  <= 1'b1;
            end
            if (written) begin
                exec   <= 1'b0;
                wb_req <= 1'b1;
            end
            if (retire) begin
                wb_req <= 1'b0;
            end
        end
    end

    // operands held until retire
    always_ff @(posedge clk) begin
        if (take) begin
            op  <= slot_op[pick_idx];
            fj  <= slot_src_a[pick_idx];
            fk  <= slot_use_imm[pick_idx] ? '0 : slot_src_b[pick_idx];
            imm <= slot_use_imm[pick_idx] ? slot_imm[pick_idx] : '0;
            fi  <= slot_dest[pick_idx];
        end
        if (written) begin
            wb_data <= result;
        end
    end

endmodule

`default_nettype wire

//--- verilog/instr_status_table.sv
// ====================
// instruction status table
// in-order entries with hazard flags and compaction on retire
// ====================
`timescale 1ns/1ps
`default_nettype none

module instr_status_table (
    input  logic                             clk,
    input  logic                             nrst,
    input  logic                             instr_valid,
    output logic                             instr_ready,
    input  logic [seq_pkg::fu_w-1:0]         instr_fu,
    input  logic [seq_pkg::op_w-1:0]         instr_op,
    input  logic [seq_pkg::reg_idx_w-1:0]    instr_src_a,
    input  logic [seq_pkg::reg_idx_w-1:0]    instr_src_b,
    input  logic                             instr_use_imm,
    input  logic [seq_pkg::reg_idx_w-1:0]    instr_imm,
    input  logic [seq_pkg::reg_idx_w-1:0]    instr_dest,
    input  logic                             alu_dispatch,
    input  logic [seq_pkg::slot_idx_w-1:0]   alu_dispatch_slot,
    input  logic                             mul_dispatch,
    input  logic [seq_pkg::slot_idx_w-1:0]   mul_dispatch_slot,
    input  logic                             alu_written,
    input  logic                             mul_written,
    input  logic                             alu_retire,
    input  logic                             mul_retire,
    output logic [seq_pkg::fu_w-1:0]         slot_fu      [seq_pkg::num_slots],
    output logic [seq_pkg::st_w-1:0]         slot_status  [seq_pkg::num_slots],
    output logic [seq_pkg::op_w-1:0]         slot_op      [seq_pkg::num_slots],
    output logic [seq_pkg::reg_idx_w-1:0]    slot_src_a   [seq_pkg::num_slots],
    output logic [seq_pkg::reg_idx_w-1:0]    slot_src_b   [seq_pkg::num_slots],
    output logic                             slot_use_imm [seq_pkg::num_slots],
    output logic [seq_pkg::reg_idx_w-1:0]    slot_imm     [seq_pkg::num_slots],
    output logic [seq_pkg::reg_idx_w-1:0]    slot_dest    [seq_pkg::num_slots],
    output logic                             slot_clear   [seq_pkg::num_slots]
);
    import seq_pkg::*;

    logic [count_w-1:0]    count;
    logic [st_w-1:0]       status_nxt [num_slots];
    logic [fu_w-1:0]       retire_fu;
    logic                  rm_hit;
    logic [slot_idx_w-1:0] rm_idx;
    logic [slot_idx_w-1:0] wr_idx;
    logic                  instr_fire;

    assign instr_ready = (count < count_w'(num_slots));
    assign instr_fire  = instr_valid && instr_ready;
    // append lands after the shift
    assign wr_idx      = slot_idx_w'(count - count_w'(rm_hit));

    // the retiring unit owns exactly one st_write entry
    assign retire_fu = alu_retire ? fu_valu : fu_vmul;

    always_comb begin
        rm_hit = 1'b0;
        rm_idx = '0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if ((alu_retire || mul_retire) && slot_status[i] == st_write &&
                slot_fu[i] == retire_fu) begin
                rm_hit = 1'b1;
                rm_idx = slot_idx_w'(i);
            end
        end
    end

    // status changes, then shift, then append
    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            status_nxt[i] = slot_status[i];
            if (slot_status[i] == st_exec) begin
                if ((alu_written && slot_fu[i] == fu_valu) ||
                    (mul_written && slot_fu[i] == fu_vmul)) begin
                    status_nxt[i] = st_write;
                end
            end
        end
        if (alu_dispatch) begin
            status_nxt[alu_dispatch_slot] = st_exec;
        end
        if (mul_dispatch) begin
            status_nxt[mul_dispatch_slot] = st_exec;
        end
        if (rm_hit) begin
            for (int i = 0; i < num_slots - 1; i++) begin
                if (i >= int'(rm_idx)) begin
                    status_nxt[i] = status_nxt[i + 1];
                end
            end
            status_nxt[num_slots - 1] = st_empty;
        end
        if (instr_fire) begin
            status_nxt[wr_idx] = st_wait;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            count <= '0;
            for (int i = 0; i < num_slots; i++) begin
                slot_status[i] <= st_empty;
            end
        end else begin
            count       <= count - count_w'(rm_hit) + count_w'(instr_fire);
            slot_status <= status_nxt;
        end
    end

    // payload follows the same shift and append
    always_ff @(posedge clk) begin
        for (int i = 0; i < num_slots - 1; i++) begin
            if (rm_hit && i >= int'(rm_idx)) begin
                slot_fu[i]      <= slot_fu[i + 1];
                slot_op[i]      <= slot_op[i + 1];
                slot_src_a[i]   <= slot_src_a[i + 1];
                slot_src_b[i]   <= slot_src_b[i + 1];
                slot_use_imm[i] <= slot_use_imm[i + 1];
                slot_imm[i]     <= slot_imm[i + 1];
                slot_dest[i]    <= slot_dest[i + 1];
            end
        end
        if (instr_fire) begin
            slot_fu[wr_idx]      <= instr_fu;
            slot_op[wr_idx]      <= instr_op;
            slot_src_a[wr_idx]   <= instr_src_a;
            slot_src_b[wr_idx]   <= instr_src_b;
            slot_use_imm[wr_idx] <= instr_use_imm;
            slot_imm[wr_idx]     <= instr_imm;
            slot_dest[wr_idx]    <= instr_dest;
        end
    end

    // raw check against every older entry still in the table
    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            slot_clear[i] = 1'b1;
            for (int j = 0; j < i; j++) begin
                if (slot_status[j] != st_empty &&
                    (slot_dest[j] == slot_src_a[i] ||
                     (!slot_use_imm[i] && slot_dest[j] == slot_src_b[i]))) begin
                    slot_clear[i] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/seq_pkg.sv
// ====================
// sequencer package
// unit codes, status codes, widths and table size
// ====================
`default_nettype none

package seq_pkg;

    // table geometry
    localparam int num_slots  = 8;
    localparam int slot_idx_w = 3;
    localparam int count_w    = 4;

    // instruction field widths
    // the immediate uses the register index width
    localparam int reg_idx_w = 5;
    localparam int op_w      = 4;
    localparam int data_w    = 32;

    // unit codes
    localparam int fu_w = 3;
    localparam logic [fu_w-1:0] fu_none = 3'd0;
    localparam logic [fu_w-1:0] fu_valu = 3'd1;
    localparam logic [fu_w-1:0] fu_vmul = 3'd2;

    // entry status codes with 2 left unused
    localparam int st_w = 3;
    localparam logic [st_w-1:0] st_empty = 3'd0;
    localparam logic [st_w-1:0] st_wait  = 3'd1;
    localparam logic [st_w-1:0] st_exec  = 3'd3;
    localparam logic [st_w-1:0] st_write = 3'd4;

endpackage

`default_nettype wire

//--- verilog/vec_sequencer.sv
// ====================
// vector sequencer top
// status table, alu and multiplier lanes, writeback arbiter
// ====================
`timescale 1ns/1ps
`default_nettype none

module vec_sequencer (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          instr_valid,
    output logic                          instr_ready,
    input  logic [seq_pkg::fu_w-1:0]      instr_fu,
    input  logic [seq_pkg::op_w-1:0]      instr_op,
    input  logic [seq_pkg::reg_idx_w-1:0] instr_src_a,
    input  logic [seq_pkg::reg_idx_w-1:0] instr_src_b,
    input  logic                          instr_use_imm,
    input  logic [seq_pkg::reg_idx_w-1:0] instr_imm,
    input  logic [seq_pkg::reg_idx_w-1:0] instr_dest,
    output logic                          alu_start,
    output logic [seq_pkg::op_w-1:0]      alu_op,
    output logic [seq_pkg::reg_idx_w-1:0] alu_fj,
    output logic [seq_pkg::reg_idx_w-1:0] alu_fk,
    output logic [seq_pkg::reg_idx_w-1:0] alu_imm,
    output logic [seq_pkg::reg_idx_w-1:0] alu_fi,
    input  logic                          alu_done,
    input  logic [seq_pkg::data_w-1:0]    alu_result,
    output logic                          mul_start,
    output logic [seq_pkg::op_w-1:0]      mul_op,
    output logic [seq_pkg::reg_idx_w-1:0] mul_fj,
    output logic [seq_pkg::reg_idx_w-1:0] mul_fk,
    output logic [seq_pkg::reg_idx_w-1:0] mul_imm,
    output logic [seq_pkg::reg_idx_w-1:0] mul_fi,
    input  logic                          mul_done,
    input  logic [seq_pkg::data_w-1:0]    mul_result,
    output logic                          reg_wr_valid,
    output logic [seq_pkg::reg_idx_w-1:0] reg_wr_addr,
    output logic [seq_pkg::data_w-1:0]    reg_wr_data,
    input  logic                          reg_wr_ready
);
    import seq_pkg::*;

    // table view shared by both lanes
    logic [fu_w-1:0]      slot_fu      [num_slots];
    logic [st_w-1:0]      slot_status  [num_slots];
    logic [op_w-1:0]      slot_op      [num_slots];
    logic [reg_idx_w-1:0] slot_src_a   [num_slots];
    logic [reg_idx_w-1:0] slot_src_b   [num_slots];
    logic                 slot_use_imm [num_slots];
    logic [reg_idx_w-1:0] slot_imm     [num_slots];
    logic [reg_idx_w-1:0] slot_dest    [num_slots];
    logic                 slot_clear   [num_slots];

    logic                  alu_dispatch;
    logic [slot_idx_w-1:0] alu_dispatch_slot;
    logic                  alu_written;
    logic                  alu_wb_req;
    logic [reg_idx_w-1:0]  alu_wb_dest;
    logic [data_w-1:0]     alu_wb_data;
    logic                  alu_retire;
    logic                  mul_dispatch;
    logic [slot_idx_w-1:0] mul_dispatch_slot;
    logic                  mul_written;
    logic                  mul_wb_req;
    logic [reg_idx_w-1:0]  mul_wb_dest;
    logic [data_w-1:0]     mul_wb_data;
    logic                  mul_retire;

    instr_status_table instr_status_table_i (
        .clk, .nrst,
        .instr_valid, .instr_ready, .instr_fu, .instr_op, .instr_src_a,
        .instr_src_b, .instr_use_imm, .instr_imm, .instr_dest,
        .alu_dispatch, .alu_dispatch_slot, .mul_dispatch, .mul_dispatch_slot,
        .alu_written, .mul_written, .alu_retire, .mul_retire,
        .slot_fu, .slot_status, .slot_op, .slot_src_a, .slot_src_b,
        .slot_use_imm, .slot_imm, .slot_dest, .slot_clear
    );

    fu_lane #(.lane_fu(fu_valu)) alu_lane_i (
        .clk, .nrst,
        .slot_fu, .slot_status, .slot_op, .slot_src_a, .slot_src_b,
        .slot_use_imm, .slot_imm, .slot_dest, .slot_clear,
        .dispatch(alu_dispatch), .dispatch_slot(alu_dispatch_slot), .written(alu_written),
        .start(alu_start), .op(alu_op), .fj(alu_fj), .fk(alu_fk), .imm(alu_imm),
        .fi(alu_fi), .done(alu_done), .result(alu_result),
        .wb_req(alu_wb_req), .wb_dest(alu_wb_dest), .wb_data(alu_wb_data),
        .retire(alu_retire)
    );

    fu_lane #(.lane_fu(fu_vmul)) mul_lane_i (
        .clk, .nrst,
        .slot_fu, .slot_status, .slot_op, .slot_src_a, .slot_src_b,
        .slot_use_imm, .slot_imm, .slot_dest, .slot_clear,
        .dispatch(mul_dispatch), .dispatch_slot(mul_dispatch_slot), .written(mul_written),
        .start(mul_start), .op(mul_op), .fj(mul_fj), .fk(mul_fk), .imm(mul_imm),
        .fi(mul_fi), .done(mul_done), .result(mul_result),
        .wb_req(mul_wb_req), .wb_dest(mul_wb_dest), .wb_data(mul_wb_data),
        .retire(mul_retire)
    );

    wb_arbiter wb_arbiter_i (
        .clk, .nrst,
        .alu_req(alu_wb_req), .alu_dest(alu_wb_dest), .alu_data(alu_wb_data),
        .mul_req(mul_wb_req), .mul_dest(mul_wb_dest), .mul_data(mul_wb_data),
        .reg_wr_valid, .reg_wr_addr, .reg_wr_data, .reg_wr_ready,
        .alu_retire, .mul_retire
    );

endmodule

`default_nettype wire

//--- verilog/wb_arbiter.sv
// ====================
// writeback arbiter
// alternates the two lanes onto one register write port
// ====================
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          alu_req,
    input  logic [seq_pkg::reg_idx_w-1:0] alu_dest,
    input  logic [seq_pkg::data_w-1:0]    alu_data,
    input  logic                          mul_req,
    input  logic [seq_pkg::reg_idx_w-1:0] mul_dest,
    input  logic [seq_pkg::data_w-1:0]    mul_data,
    output logic                          reg_wr_valid,
    output logic [seq_pkg::reg_idx_w-1:0] reg_wr_addr,
    output logic [seq_pkg::data_w-1:0]    reg_wr_data,
    input  logic                          reg_wr_ready,
    output logic                          alu_retire,
    output logic                          mul_retire
);
    logic lock;
    logic grant_mul;
    logic turn_mul;
    logic sel_mul;
    logic xfer;

    // a stalled write keeps its grant
    always_comb begin
        if (lock) begin
            sel_mul = grant_mul;
        end else if (alu_req && mul_req) begin
            sel_mul = turn_mul;
        end else begin
            sel_mul = mul_req;
        end
    end

    assign reg_wr_valid = alu_req || mul_req;
    assign reg_wr_addr  = sel_mul ? mul_dest : alu_dest;
    assign reg_wr_data  = sel_mul ? mul_data : alu_data;
    assign xfer         = reg_wr_valid && reg_wr_ready;
    assign alu_retire   = xfer && !sel_mul;
    assign mul_retire   = xfer && sel_mul;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            lock      <= 1'b0;
            grant_mul <= 1'b0;
            turn_mul  <= 1'b0;
        end else if (xfer) begin
            // loser goes first next time
            lock     <= 1'b0;
            turn_mul <= !sel_mul;
        end else if (reg_wr_valid) begin
            lock      <= 1'b1;
            grant_mul <= sel_mul;
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/seq_pkg.sv
verilog/instr_status_table.sv
verilog/fu_lane.sv
verilog/wb_arbiter.sv
verilog/vec_sequencer.sv
verif/tb_vec_sequencer.sv
